//--- tb/eepromTrace.txt
# E wren, D wrdi, P bp wrsr, S expected status, Q flag poll until WIP clears (1 must see WIP)
# W/T addr count bytes write (T cuts the last byte), R addr count expected bytes; all hex
S 00
E
S 02
D
S 00
E
W 0040 4 11 22 33 44
Q 0
R 003e 8 ff ff 11 22 33 44 ff ff
S 00
E
W 00a8 12 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 10 11 12
Q 0
R 009f 12 ff 09 0a 0b 0c 0d 0e 0f 10 11 12 03 04 05 06 07 08 ff
E
P 1
S 04
E
W 0300 2 aa bb
S 04
R 0300 2 ff ff
E
W 02f0 2 aa bb
Q 0
R 02f0 2 aa bb
E
P 2
S 08
E
W 0200 1 5a
R 0200 1 ff
P 0
S 08
E
P 0
S 00
E
W 0000 2 c3 3c
Q 0
R fffe 4 ff ff c3 3c
W 0000 1 77
R 0000 1 c3
E
T 0001 1 88
S 02
R 0000 2 c3 3c
E
W 0150 10 a0 a1 a2 a3 a4 a5 a6 a7 a8 a9 aa ab ac ad ae af
Q 1
E
W 0160 10 b0 b1 b2 b3 b4 b5 b6 b7 b8 b9 ba bb bc bd be bf
R 0160 2 00 00
Q 0
R 015e 4 ae af b0 b1
S 00

//--- src.f
common/eepromPkg.sv
common/eepromIfs.sv
rtl/serialDeserializer.sv
rtl/commandSequencer.sv
rtl/pageProgrammer.sv
rtl/memoryArray.sv
rtl/serialOutput.sv
rtl/spiEeprom.sv
tb/spiEepromTb.sv

//--- Bender.yml
package:
  name: spi_eeprom

sources:
  - common/eepromPkg.sv
  - common/eepromIfs.sv
  - rtl/serialDeserializer.sv
  - rtl/commandSequencer.sv
  - rtl/pageProgrammer.sv
  - rtl/memoryArray.sv
  - rtl/serialOutput.sv
  - rtl/spiEeprom.sv
  - target: simulation
    files:
      - tb/spiEepromTb.sv

//--- tb/spiEepromTb.sv
`timescale 1ns/1ps
`default_nettype none

module spiEepromTb;

   localparam string TraceFile = "tb/eepromTrace.txt";
   localparam int    MaxBits   = 256;                   // Longest frame in the trace
   localparam int    MaxPolls  = 40;
   localparam logic [7:0] WrenOp  = 8'h06;
   localparam logic [7:0] WrdiOp  = 8'h04;
   localparam logic [7:0] RdsrOp  = 8'h05;
   localparam logic [7:0] WrsrOp  = 8'h01;
   localparam logic [7:0] ReadOp  = 8'h03;
   localparam logic [7:0] WriteOp = 8'h02;

   logic SCK;
   logic RESET;
   logic csN;
   logic si;
   logic so;
   int   errors;
   int   checks;
   int   txLen;
   logic txBits [1:MaxBits];
   logic rxBits [1:MaxBits];                            // SO after each edge of the frame

   spiEeprom #(.AddrWidth(10), .PageBytes(16)) u_spiEeprom (
      .SCK   (SCK),
      .RESET (RESET),
      .csN   (csN),
      .si    (si),
      .so    (so)
   );

   always #2 SCK = ~SCK;

   task automatic compare(input string name, input logic [7:0] got, input logic [7:0] exp);
      checks++;
      if (got !== exp) begin
         $display("mismatch %s: got %h, expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic pushByte(input logic [7:0] b);
      for (int j = 7; j >= 0; j--) begin
         txLen++;
         txBits[txLen] = b[j];                          // MSB first
      end
   endtask

   function automatic logic [7:0] rxByteAt(input int first);
      logic [7:0] b;
      for (int j = 0; j < 8; j++) begin
         b[7-j] = rxBits[first + j];
      end
      return b;
   endfunction

   // Edge n samples bit n, SO is read in the low phase after edge n
   task automatic runFrame();
      @(posedge SCK);
      csN <= 1'b0;
      si  <= txBits[1];
      for (int n = 1; n <= txLen; n++) begin
         @(posedge SCK);
         if (n < txLen) begin
            si <= txBits[n+1];
         end else begin
            csN <= 1'b1;
            si  <= 1'b0;
         end
         @(negedge SCK);
         rxBits[n] = so;
      end
      repeat (3) @(posedge SCK);                        // Idle gap between frames
   endtask

   task automatic readHex(input int fd, output int val);
      int n;
      n = $fscanf(fd, "%h", val);
      if (n != 1) begin
         $display("Error: a trace field is missing or not hex");
         errors++;
         val = 0;
      end
   endtask

   // Skips blanks and # comment lines
   task automatic nextOp(input int fd, output int op);
      int c;
      op = -1;
      c = $fgetc(fd);
      while (c != -1 && op == -1) begin
         if (c == "#") begin
            while (c != -1 && c != "\n") c = $fgetc(fd);
         end else if (c != " " && c != "\n" && c != "\r" && c != "\t") begin
            op = c;
         end
         if (op == -1) c = $fgetc(fd);
      end
   endtask

   task automatic sendOpcode(input logic [7:0] opcode);
      txLen = 0;
      pushByte(opcode);
      runFrame();
   endtask

   task automatic writeStatus(input logic [1:0] bp);
      txLen = 0;
      pushByte(WrsrOp);
      pushByte({4'b0000, bp, 2'b00});
      runFrame();
   endtask

   task automatic readStatus(output logic [7:0] status);
      txLen = 0;
      pushByte(RdsrOp);
      pushByte(8'h00);
      pushByte(8'h00);
      runFrame();
      status = rxByteAt(10);                            // Loaded on edge 10
   endtask

   task automatic pollStatus(input int mustSeeWip);
      logic [7:0] status;
      logic       seen;
      int         polls;
      seen  = 1'b0;
      polls = 0;
      readStatus(status);
      while (status[0] && polls < MaxPolls) begin
         seen = 1'b1;
         polls++;
         readStatus(status);
      end
      if (status[0]) begin
         $display("Error: WIP still set after %0d status polls", MaxPolls);
         errors++;
      end
      if (mustSeeWip != 0 && !seen) begin
         $display("Error: WIP was never seen set right after a committed write");
         errors++;
      end
   endtask

   task automatic writeData(input int fd, input logic cut);
      int addr;
      int count;
      int val;
      txLen = 0;
      readHex(fd, addr);
      readHex(fd, count);
      pushByte(WriteOp);
      pushByte(addr[15:8]);
      pushByte(addr[7:0]);
      for (int i = 0; i < count; i++) begin
         readHex(fd, val);
         pushByte(val[7:0]);
      end
      if (cut) txLen = txLen - 3;                       // Last byte stops after five bits
      runFrame();
   endtask

   task automatic readData(input int fd);
      int addr;
      int count;
      int val;
      txLen = 0;
      readHex(fd, addr);
      readHex(fd, count);
      pushByte(ReadOp);
      pushByte(addr[15:8]);
      pushByte(addr[7:0]);
      for (int i = 0; i <= count; i++) begin
         pushByte(8'h00);                               // Spare byte lets the last reply finish
      end
      runFrame();
      for (int k = 0; k < count; k++) begin
         readHex(fd, val);
         compare($sformatf("so byte %0d of read at %h", k, addr[15:0]),
                 rxByteAt(27 + 8 * k), val[7:0]);
      end
   endtask

   initial begin : watchdog
      int fd;
      int c;
      int lines;
      lines = 0;
      fd = $fopen(TraceFile, "r");
      if (fd != 0) begin
         c = $fgetc(fd);
         while (c != -1) begin
            if (c == "\n") lines++;
            c = $fgetc(fd);
         end
         $fclose(fd);
      end
      if (lines < 1) lines = 1;
      #(lines * 600 * 4);                               // 600 cycles per trace line
      $display("Error: watchdog expired before the trace finished");
      $display("FAIL: see errors above");
      $finish;
   end

   initial begin : main
      int         fd;
      int         op;
      int         val;
      logic [7:0] status;
      errors = 0;
      checks = 0;
      txLen  = 0;
      SCK    = 1'b0;
      RESET  = 1'b1;
      csN    = 1'b1;
      si     = 1'b0;
      repeat (8) @(posedge SCK);
      RESET <= 1'b0;
      fd = $fopen(TraceFile, "r");
      if (fd == 0) begin
         $display("Error: cannot open %s", TraceFile);
         errors++;
      end else begin
         nextOp(fd, op);
         while (op != -1) begin
            case (op)
               "E": sendOpcode(WrenOp);
               "D": sendOpcode(WrdiOp);
               "P": begin
                  readHex(fd, val);
                  writeStatus(val[1:0]);
               end
               "S": begin
                  readHex(fd, val);
                  readStatus(status);
                  compare("so status", status, val[7:0]);
               end
               "Q": begin
                  readHex(fd, val);
                  pollStatus(val);
               end
               "W", "T": writeData(fd, op == "T");
               "R": readData(fd);
               default: begin
                  $display("Error: unknown trace operation %c", op);
                  errors++;
               end
            endcase
            nextOp(fd, op);
         end
         $fclose(fd);
      end
      $display("Trace done with %0d errors in %0d checks", errors, checks);
      if (errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- rtl/spiEeprom.sv
`timescale 1ns/1ps
`default_nettype none

module spiEeprom import eepromPkg::*; #(
   parameter int AddrWidth = 10,                        // 1 KiB array
   parameter int PageBytes = 16
) (
   input  logic SCK,
   input  logic RESET,
   input  logic csN,
   input  logic si,
   output logic so
);

   frameIf                         frame ();
   memReadIf #(.AddrWidth(AddrWidth)) rd ();
   progIf    #(.AddrWidth(AddrWidth)) prog ();

   logic                 wrStrobe;
   logic [AddrWidth-1:0] wrAddr;
   logic [ByteWidth-1:0] wrData;
   logic                 statusStrobe;
   logic [ByteWidth-1:0] statusByte;

   serialDeserializer u_serialDeserializer (
      .SCK   (SCK),
      .RESET (RESET),
      .csN   (csN),
      .si    (si),
      .frame (frame.source)
   );

   commandSequencer #(.AddrWidth(AddrWidth), .PageBytes(PageBytes)) u_commandSequencer (
      .SCK          (SCK),
      .RESET        (RESET),
      .frame        (frame.sink),
      .rd           (rd.requester),
      .prog         (prog.source),
      .statusStrobe (statusStrobe),
      .statusByte   (statusByte)
   );

   pageProgrammer #(.AddrWidth(AddrWidth), .PageBytes(PageBytes)) u_pageProgrammer (
      .SCK      (SCK),
      .RESET    (RESET),
      .prog     (prog.sink),
      .wrStrobe (wrStrobe),
      .wrAddr   (wrAddr),
      .wrData   (wrData)
   );

   memoryArray #(.AddrWidth(AddrWidth)) u_memoryArray (
      .SCK      (SCK),
      .rd       (rd.responder),
      .wrStrobe (wrStrobe),
      .wrAddr   (wrAddr),
      .wrData   (wrData)
   );

   serialOutput u_serialOutput (
      .SCK          (SCK),
      .RESET        (RESET),
      .csN          (csN),
      .rdValid      (rd.rdValid),                       // Array reply straight to the shifter
      .rdData       (rd.rdData),
      .statusStrobe (statusStrobe),
      .statusByte   (statusByte),
      .so           (so)
   );

endmodule

`default_nettype wire

//--- rtl/serialOutput.sv
`timescale 1ns/1ps
`default_nettype none

module serialOutput import eepromPkg::*; (
   input  logic                 SCK,
   input  logic                 RESET,
   input  logic                 csN,
   input  logic                 rdValid,
   input  logic [ByteWidth-1:0] rdData,
   input  logic                 statusStrobe,
   input  logic [ByteWidth-1:0] statusByte,
   output logic                 so
);

   logic [ByteWidth-1:0] shiftOut;

   always_ff @(posedge SCK or posedge RESET) begin
      if (RESET) begin
         shiftOut <= '0;
      end else if (csN) begin
         shiftOut <= '0;                                // Idle between frames
      end else if (rdValid) begin
         shiftOut <= rdData;
      end else if (statusStrobe) begin
         shiftOut <= statusByte;
      end else begin
         shiftOut <= {shiftOut[ByteWidth-2:0], 1'b0};   // Zeros follow the last bit
      end
   end

   assign so = shiftOut[ByteWidth-1] && !csN;           // MSB first

   // Array reply and status request come from different opcodes
   assert property (@(posedge SCK) disable iff (RESET)
      !(rdValid && statusStrobe));

endmodule

`default_nettype wire

//--- rtl/memoryArray.sv
`timescale 1ns/1ps
`default_nettype none

module memoryArray import eepromPkg::*; #(
   parameter int AddrWidth = 10
) (
   input  logic                 SCK,
   memReadIf.responder          rd,
   input  logic                 wrStrobe,
   input  logic [AddrWidth-1:0] wrAddr,
   input  logic [ByteWidth-1:0] wrData
);

   logic [ByteWidth-1:0] mem [2**AddrWidth];

   // Erased part reads all ones
   initial begin
      for (int i = 0; i < 2**AddrWidth; i++) begin
         mem[i] = '1;
      end
   end

   always_ff @(posedge SCK) begin
      rd.rdValid <= rd.rdStrobe;
      rd.rdData  <= mem[rd.rdAddr];
      if (wrStrobe) mem[wrAddr] <= wrData;
   end

endmodule

`default_nettype wire

//--- rtl/pageProgrammer.sv
`timescale 1ns/1ps
`default_nettype none

module pageProgrammer import eepromPkg::*; #(
   parameter int AddrWidth = 10,
   parameter int PageBytes = 16
) (
   input  logic                 SCK,
   input  logic                 RESET,
   progIf.sink                  prog,
   output logic                 wrStrobe,
   output logic [AddrWidth-1:0] wrAddr,
   output logic [ByteWidth-1:0] wrData
);

   localparam int PtrWidth = $clog2(PageBytes);          // PageBytes is a power of two
   localparam int CntWidth = $clog2(PageBytes + 1);

   logic [ByteWidth-1:0]          pageBuf [PageBytes];
   logic [PtrWidth-1:0]           wrPtr;
   logic [CntWidth-1:0]           bufCount;
   logic [CntWidth-1:0]           commitCount;
   logic [CntWidth-1:0]           scanIdx;
   logic [AddrWidth-PtrWidth-1:0] pageNum;
   logic [PtrWidth-1:0]           startOffset;
   logic [PtrWidth-1:0]           pageOffset;
   logic [AddrWidth-1:0]          curAddr;
   protectT                       lockLevel;
   progStateT                     state;
   logic                          accept;

   function automatic logic isLocked(input logic [AddrWidth-1:0] addr, input protectT level);
      case (level)
         2'b01:   return addr[AddrWidth-1 -: 2] == 2'b11;
         2'b10:   return addr[AddrWidth-1];
         2'b11:   return 1'b1;
         default: return 1'b0;
      endcase
   endfunction

   assign pageOffset = startOffset + scanIdx[PtrWidth-1:0];   // Wraps inside the page
   assign curAddr    = {pageNum, pageOffset};

   // A page sits wholly inside or outside a protected quarter
   assign accept = (state == ProgIdle) && prog.commitStrobe && (bufCount != '0) &&
                   !isLocked(prog.startAddr, prog.protect);

   assign prog.wip = (state != ProgIdle) || wrStrobe;

   always_ff @(posedge SCK) begin
      if (prog.bufStrobe) pageBuf[wrPtr] <= prog.bufData;
      if (accept) begin
         pageNum     <= prog.startAddr[AddrWidth-1:PtrWidth];
         startOffset <= prog.startAddr[PtrWidth-1:0];
         lockLevel   <= prog.protect;
         commitCount <= bufCount;
      end
      wrAddr <= curAddr;
      wrData <= pageBuf[scanIdx[PtrWidth-1:0]];
   end

   always_ff @(posedge SCK or posedge RESET) begin
      if (RESET) begin
         state    <= ProgIdle;
         wrPtr    <= '0;
         bufCount <= '0;
         scanIdx  <= '0;
         wrStrobe <= 1'b0;
      end else begin
         wrStrobe <= 1'b0;
         if (prog.bufStart) begin
            wrPtr    <= '0;
            bufCount <= '0;
         end else if (prog.bufStrobe) begin
            wrPtr <= wrPtr + 1'b1;                      // Last PageBytes bytes win
            if (bufCount != CntWidth'(PageBytes)) bufCount <= bufCount + 1'b1;
         end
         case (state)
            ProgIdle: begin
               scanIdx <= '0;
               if (accept) state <= ProgCommit;
            end
            ProgCommit: begin
               wrStrobe <= !isLocked(curAddr, lockLevel);
               scanIdx  <= scanIdx + 1'b1;
               if (scanIdx == commitCount - 1'b1) state <= ProgIdle;
            end
            default: state <= ProgIdle;
         endcase
      end
   end

   // Live BP from the sequencer must still cover every write
   assert property (@(posedge SCK) disable iff (RESET)
      wrStrobe |-> !isLocked(wrAddr, prog.protect));

endmodule

`default_nettype wire

//--- rtl/commandSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module commandSequencer import eepromPkg::*; #(
   parameter int AddrWidth = 10,
   parameter int PageBytes = 16
) (
   input  logic                 SCK,
   input  logic                 RESET,
   frameIf.sink                 frame,
   memReadIf.requester          rd,
   progIf.source                prog,
   output logic                 statusStrobe,
   output logic [ByteWidth-1:0] statusByte
);

   localparam int AddrBits = AddrBytes * ByteWidth;

   seqStateT              state;
   opcodeT                opcode;
   logic                  wel;
   protectT               bp;
   protectT               bpNew;
   logic [AddrBits-1:0]   addrReg;
   logic [AddrBits-1:0]   nextAddr;
   logic                  firstByte;
   logic                  addrDone;

   assign firstByte = frame.byteStrobe && (frame.byteIndex == '0);
   assign addrDone  = frame.byteStrobe && (state == SeqAddr) &&
                      (frame.byteIndex == IndexWidth'(AddrBytes));
   assign nextAddr  = {addrReg[AddrBits-ByteWidth-1:0], frame.rxByte};

   assign statusByte   = {4'b0000, bp, wel, prog.wip};
   assign prog.protect = bp;

   // Payload registers
   always_ff @(posedge SCK) begin
      if (firstByte) opcode <= opcodeT'(frame.rxByte);
      if (frame.byteStrobe && state == SeqAddr) addrReg <= nextAddr;   // Upper bits drop off
      if (addrDone) begin
         rd.rdAddr      <= nextAddr[AddrWidth-1:0];
         prog.startAddr <= nextAddr[AddrWidth-1:0];
      end else if (frame.byteStrobe && state == SeqData && opcode == READ) begin
         rd.rdAddr <= rd.rdAddr + 1'b1;                 // Wraps at array end
      end
      if (frame.byteStrobe && state == SeqData) begin
         prog.bufData <= frame.rxByte;
         if (opcode == WRSR && frame.byteIndex == IndexWidth'(1)) bpNew <= frame.rxByte[3:2];
      end
   end

   always_ff @(posedge SCK or posedge RESET) begin
      if (RESET) begin
         state             <= SeqIdle;
         wel               <= 1'b0;
         bp                <= '0;
         rd.rdStrobe       <= 1'b0;
         statusStrobe      <= 1'b0;
         prog.bufStart     <= 1'b0;
         prog.bufStrobe    <= 1'b0;
         prog.commitStrobe <= 1'b0;
      end else begin
         rd.rdStrobe       <= 1'b0;
         statusStrobe      <= 1'b0;
         prog.bufStart     <= 1'b0;
         prog.bufStrobe    <= 1'b0;
         prog.commitStrobe <= 1'b0;

         if (frame.frameStart) begin
            state <= SeqIdle;
         end else if (firstByte) begin
            // While busy only RDSR gets through
            if (frame.rxByte == RDSR) begin
               state        <= SeqData;
               statusStrobe <= 1'b1;
            end else if (prog.wip) begin
               state <= SeqIgnore;
            end else begin
               case (frame.rxByte)
                  READ, WRITE:      state <= SeqAddr;
                  WREN, WRDI, WRSR: state <= SeqData;
                  default:          state <= SeqIgnore;
               endcase
            end
         end else if (addrDone) begin
            state <= SeqData;
            if (opcode == READ) rd.rdStrobe <= 1'b1;    // First read on edge 25
            if (opcode == WRITE && wel) prog.bufStart <= 1'b1;
         end else if (frame.byteStrobe && state == SeqData) begin
            case (opcode)
               RDSR:    statusStrobe   <= 1'b1;         // Status repeats every byte
               READ:    rd.rdStrobe    <= 1'b1;
               WRITE:   prog.bufStrobe <= wel;
               default: ;
            endcase
         end

         if (frame.frameEnd) begin
            state <= SeqIdle;
            if (frame.aligned && state == SeqData && !prog.wip) begin
               case (opcode)
                  WREN: begin
                     if (frame.byteIndex == '0) wel <= 1'b1;
                  end
                  WRDI: begin
                     if (frame.byteIndex == '0) wel <= 1'b0;
                  end
                  WRSR: begin
                     if (frame.byteIndex == IndexWidth'(1) && wel) begin
                        bp  <= bpNew;
                        wel <= 1'b0;
                     end
                  end
                  WRITE: begin
                     // At least one data byte after the address
                     if (frame.byteIndex > IndexWidth'(AddrBytes) && wel) begin
                        prog.commitStrobe <= 1'b1;
                        wel               <= 1'b0;
                     end
                  end
                  default: ;
               endcase
            end
         end
      end
   end

   // A busy write cycle never lets WEL come back
   assert property (@(posedge SCK) disable iff (RESET)
      $rose(wel) |-> !prog.wip);

endmodule

`default_nettype wire

//--- rtl/serialDeserializer.sv
`timescale 1ns/1ps
`default_nettype none

module serialDeserializer import eepromPkg::*; (
   input  logic   SCK,
   input  logic   RESET,
   input  logic   csN,
   input  logic   si,
   frameIf.source frame
);

   logic [ByteWidth-1:0]  shiftIn;
   logic [2:0]            bitCnt;                       // Bit position within the byte
   logic [IndexWidth-1:0] byteCnt;
   logic                  csPrev;

   // Payload shifter, MSB first
   always_ff @(posedge SCK) begin
      if (!csN) begin
         shiftIn      <= {shiftIn[ByteWidth-2:0], si};
         frame.rxByte <= {shiftIn[ByteWidth-2:0], si};
      end
   end

   always_ff @(posedge SCK or posedge RESET) begin
      if (RESET) begin
         csPrev           <= 1'b1;
         bitCnt           <= '0;
         byteCnt          <= '0;
         frame.frameStart <= 1'b0;
         frame.frameEnd   <= 1'b0;
         frame.byteStrobe <= 1'b0;
         frame.byteIndex  <= '0;
         frame.aligned    <= 1'b0;
      end else begin
         csPrev           <= csN;
         frame.frameStart <= csPrev && !csN;
         frame.frameEnd   <= !csPrev && csN;
         frame.byteStrobe <= !csN && (bitCnt == 3'd7);
         if (csN) begin
            bitCnt  <= '0;
            byteCnt <= '0;
            if (!csPrev) frame.aligned <= (bitCnt == 3'd0);   // Judged on the closing edge
         end else begin
            bitCnt <= bitCnt + 3'd1;
            if (bitCnt == 3'd7) begin
               frame.byteIndex <= byteCnt;
               if (byteCnt != '1) byteCnt <= byteCnt + 1'b1;  // Saturate on long reads
            end
         end
      end
   end

   // Eight consecutive low samples of csN precede every byte strobe
   assert property (@(posedge SCK) disable iff (RESET)
      frame.byteStrobe |-> $past(!csN, 1) && $past(!csN, 8));

endmodule

`default_nettype wire

//--- common/eepromIfs.sv
`timescale 1ns/1ps
`default_nettype none

// Byte-level view of the serial frame
interface frameIf import eepromPkg::*; ();
   logic                  frameStart;
   logic                  byteStrobe;
   logic [ByteWidth-1:0]  rxByte;
   logic [IndexWidth-1:0] byteIndex;
   logic                  frameEnd;
   logic                  aligned;                      // Whole bytes only

   modport source (output frameStart, byteStrobe, rxByte, byteIndex, frameEnd, aligned);
   modport sink   (input  frameStart, byteStrobe, rxByte, byteIndex, frameEnd, aligned);
endinterface

// Array read port, data one cycle after the strobe
interface memReadIf import eepromPkg::*; #(parameter int AddrWidth = 10) ();
   logic                 rdStrobe;
   logic [AddrWidth-1:0] rdAddr;
   logic                 rdValid;
   logic [ByteWidth-1:0] rdData;

   modport requester (output rdStrobe, rdAddr);
   modport responder (input  rdStrobe, rdAddr, output rdValid, rdData);
endinterface

// Page buffer fill and commit request
interface progIf import eepromPkg::*; #(parameter int AddrWidth = 10) ();
   logic                 bufStart;                      // New write frame, rewind buffer
   logic                 bufStrobe;
   logic [ByteWidth-1:0] bufData;
   logic                 commitStrobe;
   logic [AddrWidth-1:0] startAddr;
   protectT              protect;
   logic                 wip;

   modport source (output bufStart, bufStrobe, bufData, commitStrobe, startAddr, protect,
                   input  wip);
   modport sink   (input  bufStart, bufStrobe, bufData, commitStrobe, startAddr, protect,
                   output wip);
endinterface

`default_nettype wire

//--- common/eepromPkg.sv
`default_nettype none

package eepromPkg;

   localparam int ByteWidth  = 8;                       // Serial byte
   localparam int AddrBytes  = 2;                       // Address bytes after READ/WRITE
   localparam int CmdBits    = 8;                       // Opcode length
   localparam int IndexWidth = 8;                       // Byte index within a frame, saturating

   // Instruction set, sent MSB first as the first byte of a frame
   typedef enum logic [CmdBits-1:0] {
      WRSR  = 8'h01,                                    // Write status (BP bits only)
      WRITE = 8'h02,                                    // Page write
      READ  = 8'h03,                                    // Sequential read
      WRDI  = 8'h04,                                    // Write disable
      RDSR  = 8'h05,                                    // Read status
      WREN  = 8'h06                                     // Write enable
   } opcodeT;

   typedef enum logic [1:0] {
      SeqIdle,                                          // Waiting for opcode
      SeqAddr,                                          // Collecting address bytes
      SeqData,                                          // Data or status stream
      SeqIgnore                                         // Unknown opcode or busy
   } seqStateT;

   typedef enum logic [1:0] {
      ProgIdle,
      ProgCommit                                        // Writing buffered bytes out
   } progStateT;

   // 00 none, 01 upper quarter, 10 upper half, 11 whole array
   typedef logic [1:0] protectT;

endpackage

`default_nettype wire
